// ==== build.f ====
hw/periph_pkg.sv
hw/periph_decode.sv
hw/byte_peri.sv
hw/gpio_ctrl.sv
hw/periph_return.sv
hw/periph_top.sv
verif/periph_checker.sv
verif/periph_tb.sv

// ==== hw/byte_peri.sv ====
// Simple byte peripheral
// Output register on the pins, a scratch register and input pin read-back
`default_nettype none
`timescale 1ns/10ps

module byte_peri (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                i_wr,
    input  logic [periph_pkg::REG_IDX_W-1:0]    i_reg_idx,
    input  logic [periph_pkg::BYTE_W-1:0]       i_data,
    input  logic [periph_pkg::BYTE_W-1:0]       i_ui_in,
    output logic [periph_pkg::BYTE_W-1:0]       o_rd_data,
    output logic [periph_pkg::BYTE_W-1:0]       o_uo_out
);

    logic [periph_pkg::BYTE_W-1:0] out_q;
    logic [periph_pkg::BYTE_W-1:0] scratch_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_q     <= '0;
            scratch_q <= '0;
        end else if (i_wr) begin
            case (i_reg_idx)
                4'd0:    out_q     <= i_data;
                4'd1:    scratch_q <= i_data;
                default: ;
            endcase
        end
    end

    // Reads are combinational
    always_comb begin
        case (i_reg_idx)
            4'd0:    o_rd_data = out_q;
            4'd1:    o_rd_data = scratch_q;
            4'd2:    o_rd_data = i_ui_in;
            default: o_rd_data = '0;
        endcase
    end

    assign o_uo_out = out_q;

endmodule

`default_nettype wire

// ==== hw/gpio_ctrl.sv ====
// GPIO block
// Output register, per-pin function select and routing of the output pins
`default_nettype none
`timescale 1ns/10ps

module gpio_ctrl (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            i_gpio_sel,
    input  logic [5:0]                      i_gpio_ofs,
    input  logic [1:0]                      i_write_n,
    input  logic [periph_pkg::BYTE_W-1:0]   i_data,
    input  logic [periph_pkg::BYTE_W-1:0]   i_ui_in,
    input  logic [periph_pkg::BYTE_W-1:0]   i_slot_uo_out [periph_pkg::NUM_SLOTS],
    output logic [periph_pkg::BYTE_W-1:0]   o_gpio_rd_data,
    output logic [periph_pkg::BYTE_W-1:0]   o_uo_out
);

    logic [periph_pkg::BYTE_W-1:0] gpio_out_q;
    logic [periph_pkg::FSEL_W-1:0] fsel_q [periph_pkg::BYTE_W];

    logic       wr_en;
    logic       out_hit;
    logic       fsel_hit;
    logic [2:0] fsel_pin;

    assign wr_en   = i_gpio_sel && (i_write_n != periph_pkg::REQ_NONE);
    assign out_hit = (i_gpio_ofs == periph_pkg::GPIO_OUT_OFS);

    // Select registers are word spaced from 0x20, so bits 5, 1 and 0 decode the range
    assign fsel_hit = ((i_gpio_ofs & 6'h23) == periph_pkg::GPIO_FSEL_OFS);
    assign fsel_pin = i_gpio_ofs[4:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out_q <= '0;
            for (int n = 0; n < periph_pkg::BYTE_W; n++) begin
                fsel_q[n] <= periph_pkg::FSEL_GPIO;
            end
        end else if (wr_en) begin
            if (out_hit) begin
                gpio_out_q <= i_data;
            end
            if (fsel_hit) begin
                fsel_q[fsel_pin] <= i_data[periph_pkg::FSEL_W-1:0];
            end
        end
    end

    // Read-back
    always_comb begin
        if (out_hit) begin
            o_gpio_rd_data = gpio_out_q;
        end else if (i_gpio_ofs == periph_pkg::GPIO_IN_OFS) begin
            o_gpio_rd_data = i_ui_in;
        end else if (fsel_hit) begin
            o_gpio_rd_data = {{(periph_pkg::BYTE_W - periph_pkg::FSEL_W){1'b0}},
                              fsel_q[fsel_pin]};
        end else begin
            o_gpio_rd_data = '0;
        end
    end

    // Each pin picks its source on its own
    for (genvar n = 0; n < periph_pkg::BYTE_W; n++) begin : g_pin
        logic [periph_pkg::SLOT_IDX_W-1:0] src_slot;
        logic                              from_slot;

        assign src_slot  = fsel_q[n][periph_pkg::SLOT_IDX_W-1:0];
        assign from_slot = fsel_q[n][periph_pkg::FSEL_W-1] &&
                           (src_slot < periph_pkg::NUM_SLOTS);

        // Unknown codes and empty slots drive the pin low
        assign o_uo_out[n] =
            (fsel_q[n] == periph_pkg::FSEL_GPIO) ? gpio_out_q[n] :
            from_slot ? i_slot_uo_out[src_slot[$clog2(periph_pkg::NUM_SLOTS)-1:0]][n] :
            1'b0;
    end

endmodule

`default_nettype wire

// ==== hw/periph_decode.sv ====
// Peripheral address decoder
// Region selects, slot and register index, and per-slot write strobes
`default_nettype none
`timescale 1ns/10ps

module periph_decode (
    input  periph_pkg::periph_addr_t              i_addr,
    input  logic [1:0]                            i_write_n,
    output logic                                  o_gpio_sel,
    output logic                                  o_simple_sel,
    output logic [periph_pkg::SLOT_IDX_W-1:0]     o_slot_idx,
    output logic [periph_pkg::REG_IDX_W-1:0]      o_reg_idx,
    output logic [5:0]                            o_gpio_ofs,
    output logic [periph_pkg::NUM_SLOTS-1:0]      o_slot_wr
);

    logic wr_req;

    assign wr_req = (i_write_n != periph_pkg::REQ_NONE);

    // GPIO block sits in the low space, so the two selects never overlap
    assign o_gpio_sel   = (i_addr.gpio.block == periph_pkg::GPIO_BLOCK);
    assign o_simple_sel = (i_addr.simple.region == periph_pkg::SIMPLE_REGION);

    // Slot view of the address
    assign o_slot_idx = i_addr.simple.slot;
    assign o_reg_idx  = i_addr.simple.reg_idx;

    // GPIO view of the address
    assign o_gpio_ofs = i_addr.gpio.ofs;

    // Only populated slots get a strobe, empty slots ignore writes
    always_comb begin
        for (int s = 0; s < periph_pkg::NUM_SLOTS; s++) begin
            o_slot_wr[s] = wr_req && o_simple_sel && (i_addr.simple.slot == s);
        end
    end

endmodule

`default_nettype wire

// ==== hw/periph_pkg.sv ====
// Peripheral hub shared definitions
// Address map, bus widths, slot count and the decoded address word
`default_nettype none

package periph_pkg;

    // Bus and register widths
    localparam int ADDR_W     = 11;
    localparam int DATA_W     = 32;
    localparam int BYTE_W     = 8;

    // Simple byte peripheral slots, only the first few are populated
    localparam int NUM_SLOTS  = 4;
    localparam int SLOT_IDX_W = 4;
    localparam int REG_IDX_W  = 4;

    // Output function select, bit 4 picks a simple slot
    localparam int                FSEL_W    = 5;
    localparam logic [FSEL_W-1:0] FSEL_GPIO = 5'd1;

    // Address map
    localparam logic [4:0] GPIO_BLOCK    = 5'd1;
    localparam logic [1:0] SIMPLE_REGION = 2'd2;
    localparam logic [5:0] GPIO_OUT_OFS  = 6'h00;
    localparam logic [5:0] GPIO_IN_OFS   = 6'h04;
    localparam logic [5:0] GPIO_FSEL_OFS = 6'h20;

    // No access on the read or write request lines
    localparam logic [1:0] REQ_NONE = 2'b11;

    // One address word, seen as a simple slot access or a GPIO block access
    typedef union packed {
        struct packed {
            logic [1:0]            region;
            logic                  spare;
            logic [SLOT_IDX_W-1:0] slot;
            logic [REG_IDX_W-1:0]  reg_idx;
        } simple;
        struct packed {
            logic [4:0] block;
            logic [5:0] ofs;
        } gpio;
    } periph_addr_t;

endpackage

`default_nettype wire

// ==== hw/periph_return.sv ====
// Read return path
// Read-data mux, captured read data held until completion, data ready
`default_nettype none
`timescale 1ns/10ps

module periph_return (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [1:0]                          i_read_n,
    input  logic [1:0]                          i_write_n,
    input  logic                                i_read_complete,
    input  logic                                i_gpio_sel,
    input  logic                                i_simple_sel,
    input  logic [periph_pkg::SLOT_IDX_W-1:0]   i_slot_idx,
    input  logic [periph_pkg::BYTE_W-1:0]       i_gpio_rd_data,
    input  logic [periph_pkg::BYTE_W-1:0]       i_slot_rd_data [periph_pkg::NUM_SLOTS],
    output logic [periph_pkg::DATA_W-1:0]       o_data,
    output logic                                o_data_ready
);

    logic [periph_pkg::DATA_W-1:0] data_q;
    logic                          hold_q;
    logic                          data_ready_q;

    logic                          read_req;
    logic                          read_act;
    logic [periph_pkg::BYTE_W-1:0] rd_byte;

    assign read_req = (i_read_n != periph_pkg::REQ_NONE);

    // Mask the request while a result is already on its way to the core
    assign read_act = read_req && !data_ready_q;

    always_comb begin
        if (i_gpio_sel) begin
            rd_byte = i_gpio_rd_data;
        end else if (i_simple_sel && (i_slot_idx < periph_pkg::NUM_SLOTS)) begin
            rd_byte = i_slot_rd_data[i_slot_idx[$clog2(periph_pkg::NUM_SLOTS)-1:0]];
        end else begin
            rd_byte = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold_q       <= 1'b0;
            data_ready_q <= 1'b0;
        end else begin
            if (i_read_complete) begin
                hold_q <= 1'b0;
            end
            // Capture wins over a completion in the same cycle
            if (!hold_q && read_act) begin
                hold_q <= 1'b1;
            end
            data_ready_q <= read_req;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold_q && read_act) begin
            data_q <= {{(periph_pkg::DATA_W - periph_pkg::BYTE_W){1'b0}}, rd_byte};
        end
    end

    assign o_data       = data_q;
    assign o_data_ready = data_ready_q || (i_write_n != periph_pkg::REQ_NONE);

endmodule

`default_nettype wire

// ==== hw/periph_top.sv ====
// Byte-wide peripheral hub
// Address decode, GPIO block, simple byte slots and the read return path
`default_nettype none
`timescale 1ns/10ps

module periph_top (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [periph_pkg::BYTE_W-1:0]     i_ui_in,
    input  logic [periph_pkg::ADDR_W-1:0]     i_addr,
    input  logic [periph_pkg::DATA_W-1:0]     i_data,
    input  logic [1:0]                        i_write_n,
    input  logic [1:0]                        i_read_n,
    input  logic                              i_read_complete,
    output logic [periph_pkg::BYTE_W-1:0]     o_uo_out,
    output logic [periph_pkg::DATA_W-1:0]     o_data,
    output logic                              o_data_ready
);

    logic                                gpio_sel;
    logic                                simple_sel;
    logic [periph_pkg::SLOT_IDX_W-1:0]   slot_idx;
    logic [periph_pkg::REG_IDX_W-1:0]    reg_idx;
    logic [5:0]                          gpio_ofs;
    logic [periph_pkg::NUM_SLOTS-1:0]    slot_wr;
    logic [periph_pkg::BYTE_W-1:0]       gpio_rd_data;

    // Per-slot read data and pin outputs
    logic [periph_pkg::BYTE_W-1:0]       slot_rd_data [periph_pkg::NUM_SLOTS];
    logic [periph_pkg::BYTE_W-1:0]       slot_uo_out  [periph_pkg::NUM_SLOTS];

    periph_decode periph_decode_inst (
        .i_addr       (periph_pkg::periph_addr_t'(i_addr)),
        .i_write_n    (i_write_n),
        .o_gpio_sel   (gpio_sel),
        .o_simple_sel (simple_sel),
        .o_slot_idx   (slot_idx),
        .o_reg_idx    (reg_idx),
        .o_gpio_ofs   (gpio_ofs),
        .o_slot_wr    (slot_wr)
    );

    gpio_ctrl gpio_ctrl_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_gpio_sel     (gpio_sel),
        .i_gpio_ofs     (gpio_ofs),
        .i_write_n      (i_write_n),
        .i_data         (i_data[periph_pkg::BYTE_W-1:0]),
        .i_ui_in        (i_ui_in),
        .i_slot_uo_out  (slot_uo_out),
        .o_gpio_rd_data (gpio_rd_data),
        .o_uo_out       (o_uo_out)
    );

    // Populated simple slots, all sharing the same byte register layout
    for (genvar s = 0; s < periph_pkg::NUM_SLOTS; s++) begin : g_slot
        byte_peri byte_peri_inst (
            .clk       (clk),
            .rst_n     (rst_n),
            .i_wr      (slot_wr[s]),
            .i_reg_idx (reg_idx),
            .i_data    (i_data[periph_pkg::BYTE_W-1:0]),
            .i_ui_in   (i_ui_in),
            .o_rd_data (slot_rd_data[s]),
            .o_uo_out  (slot_uo_out[s])
        );
    end

    periph_return periph_return_inst (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_read_n        (i_read_n),
        .i_write_n       (i_write_n),
        .i_read_complete (i_read_complete),
        .i_gpio_sel      (gpio_sel),
        .i_simple_sel    (simple_sel),
        .i_slot_idx      (slot_idx),
        .i_gpio_rd_data  (gpio_rd_data),
        .i_slot_rd_data  (slot_rd_data),
        .o_data          (o_data),
        .o_data_ready    (o_data_ready)
    );

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build the peripheral hub testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module periph_tb \
    -f build.f -o periph_sim > build.log 2>&1 \
    || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/periph_sim > sim.log 2>&1
cat sim.log
grep -q "Simulation FAILED" sim.log && { echo "Run failed"; exit 1; }
grep -q "Simulation PASSED" sim.log || { echo "Run ended without a result"; exit 1; }
exit 0

// ==== verif/periph_checker.sv ====
// Read path assertions for the peripheral hub
// Bound into the read return block
`default_nettype none
`timescale 1ns/10ps

module periph_checker (
    input logic                            clk,
    input logic                            rst_n,
    input logic                            i_read_complete,
    input logic                            i_hold,
    input logic [periph_pkg::DATA_W-1:0]   i_data,
    input logic                            i_data_ready
);

    // Data ready comes out of reset low
    ready_after_reset: assert property (@(posedge clk) !rst_n |=> !i_data_ready)
        else $error("data ready high in the cycle after reset");

    // Held read data stays put until the core completes the read
    data_held: assert property (@(posedge clk) disable iff (!rst_n)
        (i_hold && !i_read_complete) |=> $stable(i_data))
        else $error("read data changed while held");

endmodule

bind periph_return periph_checker periph_checker_inst (
    .clk             (clk),
    .rst_n           (rst_n),
    .i_read_complete (i_read_complete),
    .i_hold          (hold_q),
    .i_data          (o_data),
    .i_data_ready    (o_data_ready)
);

`default_nettype wire

// ==== verif/periph_tb.sv ====
// Testbench for the byte-wide peripheral hub
// Directed tests of GPIO, byte slots, pin routing and the read hold path
`default_nettype none
`timescale 1ns/10ps

module periph_tb;

    localparam int          RESET_CYCLES   = 10;
    // Far above the length of all tests together
    localparam int          TIMEOUT_CYCLES = 2000;
    localparam logic [10:0] GPIO_BASE      = 11'h040;
    localparam logic [10:0] SIMPLE_BASE    = 11'h400;
    localparam logic [10:0] UNMAPPED_ADDR  = 11'h200;

    logic        clk;
    logic        rst_n;
    logic [7:0]  i_ui_in;
    logic [10:0] i_addr;
    logic [31:0] i_data;
    logic [1:0]  i_write_n;
    logic [1:0]  i_read_n;
    logic        i_read_complete;
    logic [7:0]  o_uo_out;
    logic [31:0] o_data;
    logic        o_data_ready;

    integer     seed;
    int         cycle_count = 0;
    logic [7:0] gpio_val;
    logic [7:0] slot_reg0 [periph_pkg::NUM_SLOTS];

    periph_top periph_top_inst (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_ui_in         (i_ui_in),
        .i_addr          (i_addr),
        .i_data          (i_data),
        .i_write_n       (i_write_n),
        .i_read_n        (i_read_n),
        .i_read_complete (i_read_complete),
        .o_uo_out        (o_uo_out),
        .o_data          (o_data),
        .o_data_ready    (o_data_ready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation FAILED");
            $fatal(1, "Run stopped by the cycle limit");
        end
    end

    function automatic logic [7:0] rand_byte();
        logic [31:0] word;
        word = $random(seed);
        return word[7:0];
    endfunction

    function automatic logic [10:0] gpio_addr(input logic [5:0] ofs);
        return GPIO_BASE | {5'd0, ofs};
    endfunction

    // Select register for pin n sits at 0x20 plus 4 times n
    function automatic logic [10:0] fsel_addr(input int pin);
        return gpio_addr(periph_pkg::GPIO_FSEL_OFS + 6'(4 * pin));
    endfunction

    function automatic logic [10:0] slot_addr(input int slot, input int reg_ofs);
        return SIMPLE_BASE | {3'd0, 4'(slot), 4'(reg_ofs)};
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string msg);
        if (actual !== expected) begin
            $display("Fail at %0t: %s, got %h, expected %h", $time, msg, actual, expected);
            $display("Simulation FAILED");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    // One-cycle write strobe with combinational data ready
    task automatic bus_write(input logic [10:0] addr, input logic [7:0] data);
        i_addr    = addr;
        i_data    = {24'd0, data};
        i_write_n = 2'b00;
        #1;
        check_value(32'(o_data_ready), 32'd1, "data ready during write");
        @(posedge clk);
        #1;
        i_write_n = periph_pkg::REQ_NONE;
    endtask

    // Hold the read until data ready rises one cycle later
    task automatic read_start(input logic [10:0] addr);
        int wait_cycles;
        i_addr   = addr;
        i_read_n = 2'b00;
        #1;
        check_value(32'(o_data_ready), 32'd0, "data ready before read is sampled");
        wait_cycles = 0;
        while (!o_data_ready) begin
            @(posedge clk);
            #1;
            wait_cycles++;
        end
        check_value(32'(wait_cycles), 32'd1, "read latency in cycles");
    endtask

    task automatic read_finish();
        i_read_n        = periph_pkg::REQ_NONE;
        i_read_complete = 1'b1;
        @(posedge clk);
        #1;
        i_read_complete = 1'b0;
    endtask

    task automatic read_expect(input logic [10:0] addr, input logic [7:0] expected,
                               input string msg);
        read_start(addr);
        check_value(o_data, {24'd0, expected}, msg);
        read_finish();
    endtask

    task automatic test_reset();
        check_value(32'(o_uo_out), 32'd0, "output pins after reset");
        check_value(32'(o_data_ready), 32'd0, "data ready after reset");
        for (int pin = 0; pin < 8; pin++) begin
            read_expect(fsel_addr(pin), 8'(periph_pkg::FSEL_GPIO),
                        $sformatf("function select %0d after reset", pin));
        end
    endtask

    task automatic test_gpio();
        gpio_val = rand_byte();
        bus_write(gpio_addr(periph_pkg::GPIO_OUT_OFS), gpio_val);
        check_value(32'(o_uo_out), 32'(gpio_val), "GPIO register on the pins");
        read_expect(gpio_addr(periph_pkg::GPIO_OUT_OFS), gpio_val, "GPIO register read");
        i_ui_in = rand_byte();
        read_expect(gpio_addr(periph_pkg::GPIO_IN_OFS), i_ui_in, "GPIO input read");
    endtask

    task automatic test_slots();
        logic [7:0] scratch;
        for (int s = 0; s < periph_pkg::NUM_SLOTS; s++) begin
            slot_reg0[s] = rand_byte();
            scratch      = rand_byte();
            bus_write(slot_addr(s, 0), slot_reg0[s]);
            bus_write(slot_addr(s, 1), scratch);
            read_expect(slot_addr(s, 0), slot_reg0[s], $sformatf("slot %0d register 0", s));
            read_expect(slot_addr(s, 1), scratch, $sformatf("slot %0d register 1", s));
            i_ui_in = rand_byte();
            read_expect(slot_addr(s, 2), i_ui_in, $sformatf("slot %0d input read", s));
        end
        // Pins are still on the GPIO register
        check_value(32'(o_uo_out), 32'(gpio_val), "pins after slot writes");
        bus_write(slot_addr(7, 0), 8'hA5);
        read_expect(slot_addr(7, 0), 8'h00, "empty slot read");
        read_expect(UNMAPPED_ADDR, 8'h00, "unmapped read");
    endtask

    task automatic test_routing();
        logic [7:0] expected;
        // Each routed pin gets a slot bit opposite to its GPIO bit
        for (int s = 0; s < periph_pkg::NUM_SLOTS; s++) begin
            slot_reg0[s] = rand_byte();
            for (int pin = 0; pin < 8; pin++) begin
                if (pin % periph_pkg::NUM_SLOTS == s) begin
                    slot_reg0[s][pin] = ~gpio_val[pin];
                end
            end
            bus_write(slot_addr(s, 0), slot_reg0[s]);
        end
        expected = gpio_val;
        for (int pin = 0; pin < 8; pin++) begin
            bus_write(fsel_addr(pin), 8'(16 + pin % periph_pkg::NUM_SLOTS));
            expected[pin] = slot_reg0[pin % periph_pkg::NUM_SLOTS][pin];
            check_value(32'(o_uo_out), 32'(expected), $sformatf("pin %0d from slot", pin));
            read_expect(fsel_addr(pin), 8'(16 + pin % periph_pkg::NUM_SLOTS),
                        $sformatf("function select %0d read", pin));
        end
        for (int pin = 0; pin < 8; pin++) begin
            bus_write(fsel_addr(pin), 8'(periph_pkg::FSEL_GPIO));
            expected[pin] = gpio_val[pin];
            check_value(32'(o_uo_out), 32'(expected), $sformatf("pin %0d back on GPIO", pin));
        end
    endtask

    task automatic test_read_hold();
        logic [7:0] first_val;
        first_val = rand_byte();
        i_ui_in   = first_val;
        read_start(gpio_addr(periph_pkg::GPIO_IN_OFS));
        i_ui_in = ~first_val;
        repeat (5) begin
            @(posedge clk);
            #1;
            check_value(o_data, {24'd0, first_val}, "read data while held");
        end
        read_finish();
        check_value(o_data, {24'd0, first_val}, "read data after completion");
        read_expect(gpio_addr(periph_pkg::GPIO_IN_OFS), ~first_val, "input after completion");
    endtask

    initial begin
        seed            = 32'h9b64d585;
        rst_n           = 1'b0;
        i_ui_in         = 8'd0;
        i_addr          = 11'd0;
        i_data          = 32'd0;
        i_write_n       = periph_pkg::REQ_NONE;
        i_read_n        = periph_pkg::REQ_NONE;
        i_read_complete = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        test_reset();
        test_gpio();
        test_slots();
        test_routing();
        test_read_hold();
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire
